/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Mdir obj_dir
LINTFLAGS = --lint-only --timing -Wall
TOP       = phxDecodeTb
FLIST     = phxDecode.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

/* bench/phxDecodeTb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "phx_defs.svh"

module phxDecodeTb;
	import phxPkg::*;

	localparam int NUM_INSN    = 400;
	localparam int CYCLE_LIMIT = 4 * NUM_INSN + 50;
	// Packed expected record, see expectRecord for the field order
	localparam int REC_W       = 164;

	logic    clk;
	logic    rstN;
	logic    ifbV;
	insnT    insn;
	insnT    pfxWord;
	spSelT   spSel;

	logic    decV;
	regSpecT ra;
	regSpecT rb;
	regSpecT rt;
	logic    rfwr;
	logic    vrfwr;
	valueT   imm;
	prcE     prc;
	logic    load;
	logic    loadu;
	logic    store;
	memSzE   memsz;
	logic    needSteps;
	logic    br;
	logic    cjb;
	logic    isVector;

	// Actual and expected groups, one per test
	logic [23:0] actRegs;
	logic [23:0] expRegs;
	logic [1:0]  actWr;
	logic [1:0]  expWr;
	valueT       expImm;
	logic [2:0]  actPrc;
	logic [2:0]  expPrc;
	logic [6:0]  actMem;
	logic [6:0]  expMem;

	logic [REC_W-1:0] expQ[$];
	logic        chk;
	logic        started;
	logic [31:0] lcgState;
	int          cycles;
	int          errs[6];
	string       testName[6] = '{"regspec", "wren", "imm", "prc", "memop", "timing"};

	// Kept opcodes, exactly sixteen so four random bits index them
	opcodeE opcList[16] = '{OP_R2, OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI, OP_CMP,
		OP_CMPI, OP_CALL, OP_BSR, OP_RET, OP_BCC, OP_LOAD, OP_LOADU, OP_STORE, OP_NOP};
	// Memory functions repeated to weight indexed accesses
	funcE funcList[16] = '{F_ADD, F_SUB, F_AND, F_OR, F_XOR, F_SLL, F_SRL, F_SRA,
		F_LOADX, F_LOADUX, F_STOREX, F_LOADX, F_LOADUX, F_STOREX, F_ADD, F_SRA};

	phxDecodeStage phxDecodeStage_i (
		.clk       (clk),
		.rstN      (rstN),
		.ifbV      (ifbV),
		.insn      (insn),
		.pfxWord   (pfxWord),
		.spSel     (spSel),
		.decV      (decV),
		.ra        (ra),
		.rb        (rb),
		.rt        (rt),
		.rfwr      (rfwr),
		.vrfwr     (vrfwr),
		.imm       (imm),
		.prc       (prc),
		.load      (load),
		.loadu     (loadu),
		.store     (store),
		.memsz     (memsz),
		.needSteps (needSteps),
		.br        (br),
		.cjb       (cjb),
		.isVector  (isVector)
	);

	assign actRegs = {ra, rb, rt, br, cjb, isVector};
	assign actWr   = {rfwr, vrfwr};
	assign actPrc  = prc;
	assign actMem  = {load, loadu, store, memsz, needSteps};

	// ==================================================================
	// Reference model
	// ==================================================================

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Banked stack pointer for select codes 1..4
	function automatic regSpecT spBank(regSpecT r, spSelT s);
		if (r == `PHX_SP_REG && s != 3'd0 && s <= 3'd4)
			return `PHX_SP_BASE + 7'(s) - 7'd1;
		return r;
	endfunction

	function automatic logic [REC_W-1:0] expectRecord(insnT w, insnT p, spSelT s);
		logic [5:0] opc;
		logic [5:0] fn;
		logic [2:0] sz;
		logic       r2, aluOp, cjbX, brX, ret, memWr, baseLd, baseSt, idxLd, idxSt;
		logic       ld, st, ldu, vec, steps, isVec, rfwrX, vrfwrX;
		regSpecT    raX, rbX, rtX;
		valueT      immX;
		logic [2:0] prcX;
		logic [2:0] msz;
		opc    = w[`PHX_F_OPC];
		fn     = w[`PHX_F_FUNC];
		sz     = w[`PHX_F_SIZE];
		r2     = opc == OP_R2;
		aluOp  = (r2 && fn inside {F_ADD, F_SUB, F_AND, F_OR, F_XOR, F_SLL, F_SRL, F_SRA}) ||
		         opc inside {OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI, OP_CMP, OP_CMPI};
		cjbX   = opc inside {OP_CALL, OP_BSR};
		brX    = opc == OP_BCC;
		ret    = opc == OP_RET;
		raX    = spBank(w[`PHX_F_RA], s);
		rbX    = spBank(ret ? `PHX_RET_REG : w[`PHX_F_RB], s);
		rtX    = spBank(cjbX ? {4'd0, w[`PHX_F_LINK]} : w[`PHX_F_RT], s);
		// Register file writes
		memWr  = aluOp || opc inside {OP_LOAD, OP_LOADU};
		vrfwrX = memWr && rtX[6];
		rfwrX  = (memWr && !rtX[6]) || (cjbX && w[`PHX_F_LINK] != 3'd0) ||
		         (ret && rtX != 7'd0);
		// Immediate by format
		if (opc inside {OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI, OP_CMPI, OP_RET,
				OP_LOAD, OP_LOADU, OP_STORE})
			immX = 128'($signed(w[38:20]));
		else if (brX)
			immX = 128'($signed(w[41:27]));
		else if (cjbX)
			immX = 128'($signed(w[41:9]));
		else
			immX = '0;
		if (p[2:0] == `PHX_PFX_TAG)
			immX[127:19] = 109'($signed(p[41:3]));
		prcX = PRC32;
		if (aluOp && sz inside {PRC16, PRC64, PRC128})
			prcX = sz;
		// Memory class, size and stepping
		baseLd = opc inside {OP_LOAD, OP_LOADU};
		baseSt = opc == OP_STORE;
		idxLd  = r2 && fn inside {F_LOADX, F_LOADUX};
		idxSt  = r2 && fn == F_STOREX;
		ld     = baseLd || idxLd;
		st     = baseSt || idxSt;
		ldu    = opc == OP_LOADU || (r2 && fn == F_LOADUX);
		vec    = raX[6] || rtX[6] || ((idxLd || idxSt) && rbX[6]);
		msz    = MEM_TETRA;
		if (ld || st)
			msz = vec ? MEM_VECT : ((sz <= 3'd4) ? sz : MEM_TETRA);
		steps  = msz == MEM_VECT && !((baseLd || baseSt) && !raX[6]);
		isVec  = (!cjbX && raX[6]) || (r2 && rbX[6]) || (!brX && rtX[6]);
		return {raX, rbX, rtX, brX, cjbX, isVec, rfwrX, vrfwrX, immX, prcX,
			ld, ldu, st, msz, steps};
	endfunction

	// ==================================================================
	// Checks
	// ==================================================================

	task automatic reportFail(int idx, logic [127:0] expV, logic [127:0] actV);
		errs[idx]++;
		$display("[FAIL] %s expected %0h actual %0h", testName[idx], expV, actV);
	endtask

	task automatic reportEvent(int idx, string what);
		errs[idx]++;
		$display("[FAIL] %s %s", testName[idx], what);
	endtask

	// Record checks also run on idle cycles, which covers the hold
	aRegs: assert property (@(posedge clk) chk |-> actRegs == expRegs)
		else reportFail(0, 128'(expRegs), 128'($sampled(actRegs)));
	aWr: assert property (@(posedge clk) chk |-> actWr == expWr)
		else reportFail(1, 128'(expWr), 128'($sampled(actWr)));
	aImm: assert property (@(posedge clk) chk |-> imm == expImm)
		else reportFail(2, expImm, $sampled(imm));
	aPrc: assert property (@(posedge clk) chk |-> actPrc == expPrc)
		else reportFail(3, 128'(expPrc), 128'($sampled(actPrc)));
	aMem: assert property (@(posedge clk) chk |-> actMem == expMem)
		else reportFail(4, 128'(expMem), 128'($sampled(actMem)));
	// Controls stay clear until the first strobe
	aReset: assert property (@(posedge clk)
		!started |-> {decV, rfwr, vrfwr, load, store, br, cjb} == 7'd0)
		else reportFail(5, 128'd0, 128'($sampled({decV, rfwr, vrfwr, load, store, br, cjb})));
	aDecV: assert property (@(posedge clk) disable iff (!rstN) decV == $past(ifbV))
		else reportEvent(5, "decV did not follow ifbV by exactly one cycle");

	// New record visible, load the matching expectation
	always @(negedge clk) begin
		if (decV) begin
			if (expQ.size() == 0) begin
				reportEvent(5, "decV rose with no instruction in flight");
			end else begin
				{expRegs, expWr, expImm, expPrc, expMem} = expQ.pop_front();
				chk = 1'b1;
			end
		end
	end

	// ==================================================================
	// Stimulus
	// ==================================================================

	task automatic issueOne();
		insnT        w;
		insnT        p;
		logic [31:0] r;
		logic        gap;
		r = lcgNext();
		w = {r[9:0], lcgNext()};
		w[`PHX_F_OPC] = opcList[r[13:10]];
		r = lcgNext();
		// Mostly known functions, some raw codes
		if (r[2:0] != 3'd0)
			w[`PHX_F_FUNC] = funcList[r[6:3]];
		// Bias specifiers toward the stack pointer
		if (r[8:7] == 2'd0)
			w[`PHX_F_RA] = `PHX_SP_REG;
		if (r[10:9] == 2'd0)
			w[`PHX_F_RB] = `PHX_SP_REG;
		if (r[12:11] == 2'd0)
			w[`PHX_F_RT] = `PHX_SP_REG;
		p = {r[30:21], lcgNext()};
		// One in four tagged, the rest carry a wrong tag
		if (r[14:13] == 2'd0)
			p[2:0] = `PHX_PFX_TAG;
		else if (p[2:0] == `PHX_PFX_TAG)
			p[2:0] = 3'd6;
		gap     = r[19:18] == 2'd0;
		insn    = w;
		pfxWord = p;
		spSel   = r[17:15];
		ifbV    = 1'b1;
		started = 1'b1;
		expQ.push_back(expectRecord(w, p, r[17:15]));
		@(posedge clk);
		#2;
		ifbV = 1'b0;
		// Idle cycle with junk on the bus
		if (gap) begin
			insn    = ~w;
			pfxWord = ~p;
			@(posedge clk);
			#2;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin : mainSeq
		int nFail;
		rstN     = 1'b1;
		ifbV     = 1'b0;
		insn     = '0;
		pfxWord  = '0;
		spSel    = '0;
		chk      = 1'b0;
		started  = 1'b0;
		lcgState = 32'hd39c2455;
		#1 rstN = 1'b0;
		repeat (4) @(posedge clk);
		#2 rstN = 1'b1;
		@(posedge clk);
		#2;
		for (int n = 0; n < NUM_INSN; n++)
			issueOne();
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (3) @(posedge clk);
		nFail = 0;
		for (int i = 0; i < 6; i++) begin
			$display("%-8s %s errors %0d", testName[i], (errs[i] == 0) ? "PASS" : "FAIL",
				errs[i]);
			if (errs[i] != 0)
				nFail++;
		end
		$display("Tests 6 passed %0d failed %0d instructions %0d", 6 - nFail, nFail, NUM_INSN);
		if (nFail == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Run limit
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, %0d records outstanding", cycles, expQ.size());
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* common/phxPkg.sv */
`default_nettype none

`include "phx_defs.svh"

package phxPkg;

	// ==================================================================
	// Vector types
	// ==================================================================

	// Raw fetch word, instruction or postfix
	typedef logic [`PHX_INSN_W-1:0]  insnT;
	// Top bit flags a vector register
	typedef logic [`PHX_REG_W-1:0]   regSpecT;
	typedef logic [`PHX_VALUE_W-1:0] valueT;
	// Stack pointer bank select
	typedef logic [2:0]              spSelT;

	// ==================================================================
	// Encodings
	// ==================================================================

	typedef enum logic [5:0] {
		OP_R2    = 6'h02,
		OP_ADDI  = 6'h04,
		OP_SUBFI = 6'h05,
		OP_ANDI  = 6'h08,
		OP_ORI   = 6'h09,
		OP_XORI  = 6'h0A,
		OP_CMP   = 6'h0C,
		OP_CMPI  = 6'h0D,
		OP_CALL  = 6'h20,
		OP_BSR   = 6'h21,
		OP_RET   = 6'h22,
		OP_BCC   = 6'h28,
		OP_LOAD  = 6'h30,
		OP_LOADU = 6'h31,
		OP_STORE = 6'h38,
		OP_NOP   = 6'h3F
	} opcodeE;

	// Function codes of the R2 format
	typedef enum logic [5:0] {
		F_ADD    = 6'h04,
		F_SUB    = 6'h05,
		F_AND    = 6'h08,
		F_OR     = 6'h09,
		F_XOR    = 6'h0A,
		F_SLL    = 6'h10,
		F_SRL    = 6'h11,
		F_SRA    = 6'h12,
		F_LOADX  = 6'h30,
		F_LOADUX = 6'h31,
		F_STOREX = 6'h38
	} funcE;

	// Size field codes, also the operation precision
	typedef enum logic [2:0] {
		PRC8   = 3'd0,
		PRC16  = 3'd1,
		PRC32  = 3'd2,
		PRC64  = 3'd3,
		PRC128 = 3'd4
	} prcE;

	typedef enum logic [2:0] {
		MEM_BYTE  = 3'd0,
		MEM_WYDE  = 3'd1,
		MEM_TETRA = 3'd2,
		MEM_OCTA  = 3'd3,
		MEM_HEXI  = 3'd4,
		MEM_VECT  = 3'd5
	} memSzE;

	// ALU group of the R2 functions
	function automatic logic isAluFunc(funcE fn);
		return fn inside {F_ADD, F_SUB, F_AND, F_OR, F_XOR, F_SLL, F_SRL, F_SRA};
	endfunction

endpackage

`default_nettype wire

/* common/phx_defs.svh */
`ifndef PHX_DEFS_SVH
`define PHX_DEFS_SVH

// Word widths
`define PHX_INSN_W   42
`define PHX_VALUE_W  128
`define PHX_REG_W    7
`define PHX_REG_VEC  6

// Special register specifiers
`define PHX_SP_REG   7'd47
`define PHX_SP_BASE  7'd60
`define PHX_RET_REG  7'd59
`define PHX_PFX_TAG  3'd2

// Instruction word fields
`define PHX_F_OPC    5:0
`define PHX_F_RT     12:6
`define PHX_F_RA     19:13
`define PHX_F_RB     26:20
`define PHX_F_FUNC   32:27
`define PHX_F_SIZE   41:39
`define PHX_F_IMM    38:20
`define PHX_F_BDISP  41:27
`define PHX_F_LINK   8:6
`define PHX_F_TGT    41:9

// Postfix word fields
`define PHX_F_PTAG   2:0
`define PHX_F_PIMM   41:3

`endif

/* design/decode/phxImmDecode.sv */
`default_nettype none
`timescale 1ns/1ps

`include "phx_defs.svh"

module phxImmDecode (
	input  phxPkg::insnT  insn,
	input  phxPkg::insnT  pfxWord,
	output phxPkg::valueT imm
);
	import phxPkg::*;

	opcodeE      opc;
	logic        pfxHit;
	logic [18:0] immFld;
	logic [14:0] bDisp;
	logic [32:0] tgt;
	logic [38:0] pfxImm;

	assign opc    = opcodeE'(insn[`PHX_F_OPC]);
	assign immFld = insn[`PHX_F_IMM];
	assign bDisp  = insn[`PHX_F_BDISP];
	assign tgt    = insn[`PHX_F_TGT];

	// Postfix only counts when its tag matches
	assign pfxHit = pfxWord[`PHX_F_PTAG] == `PHX_PFX_TAG;
	assign pfxImm = pfxWord[`PHX_F_PIMM];

	always_comb begin
		case (opc)
			// 19-bit immediate or displacement
			OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI, OP_CMPI,
			OP_RET, OP_LOAD, OP_LOADU, OP_STORE:
				imm = {{(`PHX_VALUE_W-19){immFld[18]}}, immFld};
			// Conditional branch displacement
			OP_BCC:
				imm = {{(`PHX_VALUE_W-15){bDisp[14]}}, bDisp};
			OP_CALL, OP_BSR:
				imm = {{(`PHX_VALUE_W-33){tgt[32]}}, tgt};
			default:
				imm = '0;
		endcase
		// Postfix replaces everything above the 19-bit field
		if (pfxHit)
			imm[`PHX_VALUE_W-1:19] = {{(`PHX_VALUE_W-19-39){pfxImm[38]}}, pfxImm};
	end

endmodule

`default_nettype wire

/* design/decode/phxMemOpDecode.sv */
`default_nettype none
`timescale 1ns/1ps

`include "phx_defs.svh"

module phxMemOpDecode (
	input  phxPkg::insnT    insn,
	input  phxPkg::regSpecT ra,
	input  phxPkg::regSpecT rb,
	input  phxPkg::regSpecT rt,
	output logic            load,
	output logic            loadu,
	output logic            store,
	output phxPkg::memSzE   memsz,
	output logic            needSteps
);
	import phxPkg::*;

	opcodeE opc;
	funcE   fn;
	prcE    szFld;
	memSzE  baseSz;
	logic   isR2;
	logic   loadr;
	logic   loadn;
	logic   storer;
	logic   storen;
	logic   vecAcc;

	assign opc   = opcodeE'(insn[`PHX_F_OPC]);
	assign fn    = funcE'(insn[`PHX_F_FUNC]);
	assign szFld = prcE'(insn[`PHX_F_SIZE]);
	assign isR2  = opc == OP_R2;

	// Base forms and indexed forms
	assign loadr  = opc == OP_LOAD || opc == OP_LOADU;
	assign storer = opc == OP_STORE;
	assign loadn  = isR2 && (fn == F_LOADX || fn == F_LOADUX);
	assign storen = isR2 && fn == F_STOREX;

	assign load  = loadr | loadn;
	assign store = storer | storen;
	// Zero extending loads
	assign loadu = opc == OP_LOADU || (isR2 && fn == F_LOADUX);

	// Size code to access width
	always_comb begin
		case (szFld)
			PRC8:    baseSz = MEM_BYTE;
			PRC16:   baseSz = MEM_WYDE;
			PRC32:   baseSz = MEM_TETRA;
			PRC64:   baseSz = MEM_OCTA;
			PRC128:  baseSz = MEM_HEXI;
			default: baseSz = MEM_TETRA;
		endcase
	end

	// Vector base, vector data, or vector index on indexed forms
	assign vecAcc = ra[`PHX_REG_VEC] | rt[`PHX_REG_VEC] |
	                ((loadn | storen) & rb[`PHX_REG_VEC]);

	always_comb begin
		memsz = MEM_TETRA;
		if (load | store)
			memsz = vecAcc ? MEM_VECT : baseSz;
	end

	// Base form with scalar base address moves as one block
	assign needSteps = memsz == MEM_VECT && !((loadr | storer) && !ra[`PHX_REG_VEC]);

	always_comb begin
		assert (!(load && store))
			else $error("phxMemOpDecode: load and store both set");
	end

endmodule

`default_nettype wire

/* design/decode/phxPrecisionDecode.sv */
`default_nettype none
`timescale 1ns/1ps

`include "phx_defs.svh"

module phxPrecisionDecode (
	input  phxPkg::insnT insn,
	output phxPkg::prcE  prc
);
	import phxPkg::*;

	opcodeE opc;
	funcE   fn;
	prcE    szFld;
	logic   sized;

	assign opc   = opcodeE'(insn[`PHX_F_OPC]);
	assign fn    = funcE'(insn[`PHX_F_FUNC]);
	assign szFld = prcE'(insn[`PHX_F_SIZE]);

	// Ops that honour the size field
	always_comb begin
		case (opc)
			OP_R2:   sized = isAluFunc(fn);
			OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI,
			OP_CMP, OP_CMPI:
				sized = 1'b1;
			default: sized = 1'b0;
		endcase
	end

	// 32 bits unless a narrower or wider size is asked for
	always_comb begin
		prc = PRC32;
		if (sized) begin
			case (szFld)
				PRC16:   prc = PRC16;
				PRC64:   prc = PRC64;
				PRC128:  prc = PRC128;
				default: prc = PRC32;
			endcase
		end
	end

	// Byte precision has no ALU datapath
	always_comb begin
		assert (prc != PRC8)
			else $error("phxPrecisionDecode: byte precision decoded");
	end

endmodule

`default_nettype wire

/* design/decode/phxRegSpecDecode.sv */
`default_nettype none
`timescale 1ns/1ps

`include "phx_defs.svh"

module phxRegSpecDecode (
	input  phxPkg::insnT    insn,
	input  phxPkg::spSelT   spSel,
	output phxPkg::regSpecT ra,
	output phxPkg::regSpecT rb,
	output phxPkg::regSpecT rt,
	output logic            rfwr,
	output logic            vrfwr,
	output logic            br,
	output logic            cjb,
	output logic            hasRa,
	output logic            hasRb,
	output logic            hasRt,
	output logic            isVector
);
	import phxPkg::*;

	opcodeE  opc;
	funcE    fn;
	regSpecT raFld;
	regSpecT rbFld;
	regSpecT rtFld;

	// Scalar r47 maps onto the banked stack pointer
	// Select codes 0 and 5..7 leave it alone
	function automatic regSpecT spSub(regSpecT r, spSelT sel);
		regSpecT res;
		res = r;
		if (r == `PHX_SP_REG && sel >= 3'd1 && sel <= 3'd4)
			res = `PHX_SP_BASE + regSpecT'(sel) - 7'd1;
		return res;
	endfunction

	assign opc = opcodeE'(insn[`PHX_F_OPC]);
	assign fn  = funcE'(insn[`PHX_F_FUNC]);

	// Flow control classes
	assign br  = opc == OP_BCC;
	assign cjb = opc == OP_CALL || opc == OP_BSR;

	// ==================================================================
	// Specifier fields
	// ==================================================================

	always_comb begin
		raFld = insn[`PHX_F_RA];
		rbFld = insn[`PHX_F_RB];
		rtFld = insn[`PHX_F_RT];
		// RET pops its address from the return register
		if (opc == OP_RET)
			rbFld = `PHX_RET_REG;
		// Link register is a 3-bit scalar number
		if (cjb)
			rtFld = {4'd0, insn[`PHX_F_LINK]};
	end

	assign ra = spSub(raFld, spSel);
	assign rb = spSub(rbFld, spSel);
	assign rt = spSub(rtFld, spSel);

	// ==================================================================
	// Register file write enables
	// ==================================================================

	always_comb begin
		rfwr  = 1'b0;
		vrfwr = 1'b0;
		case (opc)
			OP_R2: begin
				// Memory and unknown functions write nothing here
				if (isAluFunc(fn)) begin
					vrfwr = rt[`PHX_REG_VEC];
					rfwr  = ~rt[`PHX_REG_VEC];
				end
			end
			OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI,
			OP_CMP, OP_CMPI, OP_LOAD, OP_LOADU: begin
				vrfwr = rt[`PHX_REG_VEC];
				rfwr  = ~rt[`PHX_REG_VEC];
			end
			// Link of zero means no link write
			OP_CALL, OP_BSR: rfwr = insn[`PHX_F_LINK] != 3'd0;
			OP_RET:          rfwr = rt != '0;
			default: ;
		endcase
	end

	// Operand presence
	assign hasRa = ~cjb;
	assign hasRb = opc == OP_R2;
	assign hasRt = ~br;

	// Any live vector operand makes the op a vector op
	assign isVector = (hasRa & ra[`PHX_REG_VEC]) |
	                  (hasRb & rb[`PHX_REG_VEC]) |
	                  (hasRt & rt[`PHX_REG_VEC]);

	// One register file per write
	always_comb begin
		assert (!(rfwr && vrfwr))
			else $error("phxRegSpecDecode: scalar and vector write both set");
	end

endmodule

`default_nettype wire

/* design/phxDecodeStage.sv */
`default_nettype none
`timescale 1ns/1ps

module phxDecodeStage (
	input  logic            clk,
	input  logic            rstN,
	input  logic            ifbV,
	input  phxPkg::insnT    insn,
	input  phxPkg::insnT    pfxWord,
	input  phxPkg::spSelT   spSel,
	output logic            decV,
	output phxPkg::regSpecT ra,
	output phxPkg::regSpecT rb,
	output phxPkg::regSpecT rt,
	output logic            rfwr,
	output logic            vrfwr,
	output phxPkg::valueT   imm,
	output phxPkg::prcE     prc,
	output logic            load,
	output logic            loadu,
	output logic            store,
	output phxPkg::memSzE   memsz,
	output logic            needSteps,
	output logic            br,
	output logic            cjb,
	output logic            isVector
);
	import phxPkg::*;

	// Combinational decode record
	regSpecT raD;
	regSpecT rbD;
	regSpecT rtD;
	logic    rfwrD;
	logic    vrfwrD;
	logic    brD;
	logic    cjbD;
	logic    isVectorD;
	valueT   immD;
	prcE     prcD;
	logic    loadD;
	logic    loaduD;
	logic    storeD;
	memSzE   memszD;
	logic    needStepsD;

	// ==================================================================
	// Decoders, all fed from the same fetch word
	// ==================================================================

	phxRegSpecDecode phxRegSpecDecode_i (
		.insn     (insn),
		.spSel    (spSel),
		.ra       (raD),
		.rb       (rbD),
		.rt       (rtD),
		.rfwr     (rfwrD),
		.vrfwr    (vrfwrD),
		.br       (brD),
		.cjb      (cjbD),
		.hasRa    (),
		.hasRb    (),
		.hasRt    (),
		.isVector (isVectorD)
	);

	phxImmDecode phxImmDecode_i (
		.insn    (insn),
		.pfxWord (pfxWord),
		.imm     (immD)
	);

	phxPrecisionDecode phxPrecisionDecode_i (
		.insn (insn),
		.prc  (prcD)
	);

	// Takes final specifiers so vector flags come from one place
	phxMemOpDecode phxMemOpDecode_i (
		.insn      (insn),
		.ra        (raD),
		.rb        (rbD),
		.rt        (rtD),
		.load      (loadD),
		.loadu     (loaduD),
		.store     (storeD),
		.memsz     (memszD),
		.needSteps (needStepsD)
	);

	// ==================================================================
	// Decode record register
	// ==================================================================

	// Control bits, cleared on reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decV  <= 1'b0;
			rfwr  <= 1'b0;
			vrfwr <= 1'b0;
			load  <= 1'b0;
			store <= 1'b0;
			br    <= 1'b0;
			cjb   <= 1'b0;
		end else begin
			decV <= ifbV;
			if (ifbV) begin
				rfwr  <= rfwrD;
				vrfwr <= vrfwrD;
				load  <= loadD;
				store <= storeD;
				br    <= brD;
				cjb   <= cjbD;
			end
		end
	end

	// Payload, held between strobes
	always_ff @(posedge clk) begin
		if (ifbV) begin
			ra        <= raD;
			rb        <= rbD;
			rt        <= rtD;
			imm       <= immD;
			prc       <= prcD;
			loadu     <= loaduD;
			memsz     <= memszD;
			needSteps <= needStepsD;
			isVector  <= isVectorD;
		end
	end

	// Output valid only one clock behind a fetch strobe
	a_decVAfterIfb: assert property (@(posedge clk) disable iff (!rstN) decV |-> $past(ifbV))
		else $error("phxDecodeStage: decV without a fetch strobe");

endmodule

`default_nettype wire

/* phxDecode.f */
+incdir+common
common/phxPkg.sv
design/decode/phxRegSpecDecode.sv
design/decode/phxImmDecode.sv
design/decode/phxPrecisionDecode.sv
design/decode/phxMemOpDecode.sv
design/phxDecodeStage.sv
bench/phxDecodeTb.sv
